//--- design/rv32i_pkg.sv
// RV32I ISA definitions shared by the comparator cluster: data word and compare encodings.
`default_nettype none

package rv32i_pkg;

    // A 32-bit architectural data word.
    typedef logic [31:0] word_t;

    // --------------------------------------------------
    // Compare encodings
    // --------------------------------------------------

    // Branch funct3 field of the B-type instructions.
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_funct3_t;

    // Set-less-than funct3 field.
    // SLTI and SLTIU share these codes and differ only in operand two.
    typedef enum logic [2:0] {
        SLT  = 3'b010,
        SLTU = 3'b011
    } arith_funct3_t;

    // One 3-bit op field, read as a branch code or as an ALU code.
    // The is_br flag that travels with it selects the valid view.
    typedef union packed {
        branch_funct3_t br;
        arith_funct3_t  alu;
    } cmp_op_u;

endpackage

`default_nettype wire

//--- design/ooo_pkg.sv
// Out-of-order machine sizing: ROB tags and comparator reservation station slots.
`default_nettype none

package ooo_pkg;

    // --------------------------------------------------
    // Reorder buffer
    // --------------------------------------------------

    // Number of ROB entries, which is also the number of tag values.
    localparam int ROB_DEPTH = 8;

    // ROB tag. Live producers use tags 1 to 7.
    typedef logic [2:0] tag_t;

    // A source tagged with this value already holds its operand.
    localparam tag_t TAG_NONE = 3'd0;

    // --------------------------------------------------
    // Comparator reservation station
    // --------------------------------------------------

    // Number of station slots, each with its own result lane.
    localparam int NUM_CMP_RS = 3;

    // Slot index. The value 3 is not a slot.
    typedef logic [1:0] slot_idx_t;

    // Free-slot encoder output when every slot is busy.
    localparam slot_idx_t SLOT_NONE = 2'd3;

endpackage

`default_nettype wire

//--- design/cmp_ifs.sv
// Issue and result interfaces that connect the comparator cluster stages.
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// Dispatch to station
// --------------------------------------------------

interface cmp_issue_if;

    logic                valid;
    logic                is_br;
    rv32i_pkg::cmp_op_u  op;
    rv32i_pkg::word_t    vj;
    rv32i_pkg::word_t    vk;
    ooo_pkg::tag_t       qj;
    ooo_pkg::tag_t       qk;
    ooo_pkg::tag_t       dest;
    logic                br_pred;
    rv32i_pkg::word_t    pc;
    rv32i_pkg::word_t    b_imm;

    // Count of idle station slots, 0 to 3.
    logic [1:0]          free_slots;

    modport dispatch (
        output valid, is_br, op, vj, vk, qj, qk, dest, br_pred, pc, b_imm,
        input  free_slots
    );

    modport station (
        input  valid, is_br, op, vj, vk, qj, qk, dest, br_pred, pc, b_imm,
        output free_slots
    );

endinterface

// --------------------------------------------------
// Station to write-back, one lane per slot
// --------------------------------------------------

interface cmp_result_if;

    logic                valid      [ooo_pkg::NUM_CMP_RS];
    rv32i_pkg::word_t    val        [ooo_pkg::NUM_CMP_RS];
    ooo_pkg::tag_t       tag        [ooo_pkg::NUM_CMP_RS];
    logic                mispredict [ooo_pkg::NUM_CMP_RS];
    rv32i_pkg::word_t    pc         [ooo_pkg::NUM_CMP_RS];

    modport station (output valid, val, tag, mispredict, pc);

    modport wb (input valid, val, tag, mispredict, pc);

endinterface

`default_nettype wire

//--- design/cmp_unit.sv
// Combinational comparator that evaluates one branch or set-less-than for a station slot.
`timescale 1ns/1ps
`default_nettype none

module cmp_unit (
    input  rv32i_pkg::word_t   a,
    input  rv32i_pkg::word_t   b,
    input  logic               is_br,
    input  rv32i_pkg::cmp_op_u op,
    output logic               taken
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        taken = 1'b0;
        if (is_br) begin
            case (op.br)
                rv32i_pkg::BEQ:  taken = eq;
                rv32i_pkg::BNE:  taken = !eq;
                rv32i_pkg::BLT:  taken = lt_s;
                rv32i_pkg::BGE:  taken = !lt_s;
                rv32i_pkg::BLTU: taken = lt_u;
                rv32i_pkg::BGEU: taken = !lt_u;
                default:         taken = 1'b0;
            endcase
        end else begin
            case (op.alu)
                rv32i_pkg::SLT:  taken = lt_s;
                rv32i_pkg::SLTU: taken = lt_u;
                default:         taken = 1'b0;
            endcase
        end
    end

    // Dispatch only ever hands over SLT or SLTU codes in the ALU view.
    always_comb begin
        assert final (is_br || $isunknown({is_br, op})
                      || op.alu inside {rv32i_pkg::SLT, rv32i_pkg::SLTU})
            else $error("cmp_unit: illegal ALU compare code %b", op.alu);
    end

endmodule

`default_nettype wire

//--- design/cmp_dispatch.sv
// Dispatch stage that resolves operands against the ROB and registers one issue.
`timescale 1ns/1ps
`default_nettype none

module cmp_dispatch (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                disp_valid,
    input  logic                disp_is_br,
    input  logic                disp_br_pred,
    input  logic                disp_use_imm,
    input  rv32i_pkg::cmp_op_u  disp_op,
    input  ooo_pkg::tag_t       disp_rs1_tag,
    input  ooo_pkg::tag_t       disp_rs2_tag,
    input  ooo_pkg::tag_t       disp_dest,
    input  rv32i_pkg::word_t    disp_rs1_val,
    input  rv32i_pkg::word_t    disp_rs2_val,
    input  rv32i_pkg::word_t    disp_imm,
    input  rv32i_pkg::word_t    disp_pc,
    input  logic                rob_ready [ooo_pkg::ROB_DEPTH],
    input  rv32i_pkg::word_t    rob_vals  [ooo_pkg::ROB_DEPTH],
    output logic                disp_ready,
    cmp_issue_if.dispatch       issue
);

    logic             accept;
    rv32i_pkg::word_t vj_res;
    rv32i_pkg::word_t vk_res;
    ooo_pkg::tag_t    qj_res;
    ooo_pkg::tag_t    qk_res;

    // The instruction held in the issue register still needs a slot.
    assign disp_ready = (issue.free_slots > {1'b0, issue.valid});
    assign accept     = disp_valid && disp_ready;

    // --------------------------------------------------
    // Operand resolution
    // --------------------------------------------------

    always_comb begin
        vj_res = disp_rs1_val;
        qj_res = disp_rs1_tag;
        if (disp_rs1_tag != ooo_pkg::TAG_NONE && rob_ready[disp_rs1_tag]) begin
            vj_res = rob_vals[disp_rs1_tag];
            qj_res = ooo_pkg::TAG_NONE;
        end

        // SLTI and SLTIU compare against the immediate, never a register.
        vk_res = disp_rs2_val;
        qk_res = disp_rs2_tag;
        if (disp_use_imm) begin
            vk_res = disp_imm;
            qk_res = ooo_pkg::TAG_NONE;
        end else if (disp_rs2_tag != ooo_pkg::TAG_NONE && rob_ready[disp_rs2_tag]) begin
            vk_res = rob_vals[disp_rs2_tag];
            qk_res = ooo_pkg::TAG_NONE;
        end
    end

    // --------------------------------------------------
    // Issue register
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue.is_br   <= disp_is_br;
            issue.op      <= disp_op;
            issue.vj      <= vj_res;
            issue.vk      <= vk_res;
            issue.qj      <= qj_res;
            issue.qk      <= qk_res;
            issue.dest    <= disp_dest;
            issue.br_pred <= disp_br_pred;
            issue.pc      <= disp_pc;
            issue.b_imm   <= disp_imm;
        end
    end

    // Tag 0 marks a present operand, so it can never name a result.
    assert property (@(posedge clk) disable iff (rst || flush)
        accept |-> disp_dest != ooo_pkg::TAG_NONE)
        else $error("cmp_dispatch: accepted instruction with zero dest");

endmodule

`default_nettype wire

//--- design/cmp_rs.sv
// Comparator reservation station that waits on ROB tags and evaluates one result per slot.
`timescale 1ns/1ps
`default_nettype none

module cmp_rs (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    cmp_issue_if.station      issue,
    input  logic              rob_ready [ooo_pkg::ROB_DEPTH],
    input  rv32i_pkg::word_t  rob_vals  [ooo_pkg::ROB_DEPTH],
    cmp_result_if.station     res
);

    localparam int N = ooo_pkg::NUM_CMP_RS;

    // Slot state.
    logic               busy    [N];
    logic               is_br   [N];
    rv32i_pkg::cmp_op_u op      [N];
    rv32i_pkg::word_t   vj      [N];
    rv32i_pkg::word_t   vk      [N];
    ooo_pkg::tag_t      qj      [N];
    ooo_pkg::tag_t      qk      [N];
    ooo_pkg::tag_t      dest    [N];
    logic               br_pred [N];
    rv32i_pkg::word_t   pc      [N];
    rv32i_pkg::word_t   b_imm   [N];

    logic               taken   [N];
    logic               fire    [N];
    ooo_pkg::slot_idx_t free_idx;
    logic [1:0]         free_cnt;

    // --------------------------------------------------
    // Free slot search
    // --------------------------------------------------

    always_comb begin
        free_idx = ooo_pkg::SLOT_NONE;
        free_cnt = 2'd0;
        for (int i = N - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = ooo_pkg::slot_idx_t'(i);
                free_cnt = free_cnt + 2'd1;
            end
        end
    end

    assign issue.free_slots = free_cnt;

    // --------------------------------------------------
    // Per-slot comparators
    // --------------------------------------------------

    for (genvar g = 0; g < N; g++) begin : g_slot
        // Idle slots are evaluated as branches so stale fields never look like an ALU op.
        cmp_unit u_cmp (
            .a     (vj[g]),
            .b     (vk[g]),
            .is_br (is_br[g] || !busy[g]),
            .op    (op[g]),
            .taken (taken[g])
        );

        assign fire[g] = busy[g] && qj[g] == ooo_pkg::TAG_NONE && qk[g] == ooo_pkg::TAG_NONE;

        // The slot keeps its fields while its result pulses, and a set-less-than never mispredicts.
        assert property (@(posedge clk) disable iff (rst || flush)
            res.valid[g] && !is_br[g] |-> !res.mispredict[g])
            else $error("cmp_rs: slot %0d flagged a mispredict for a set-less-than", g);
    end

    // --------------------------------------------------
    // Busy bits and result pulses
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < N; i++) begin
                busy[i]      <= 1'b0;
                res.valid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                res.valid[i] <= fire[i];
                if (fire[i]) begin
                    busy[i] <= 1'b0;
                end else if (issue.valid && free_idx == ooo_pkg::slot_idx_t'(i)) begin
                    busy[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (fire[i]) begin
                if (!is_br[i]) begin
                    res.val[i] <= {31'd0, taken[i]};
                end else if (taken[i]) begin
                    res.val[i] <= pc[i] + b_imm[i];
                end else begin
                    res.val[i] <= pc[i] + 32'd4;
                end
                res.tag[i]        <= dest[i];
                res.mispredict[i] <= is_br[i] && (br_pred[i] != taken[i]);
                res.pc[i]         <= pc[i];
            end
        end
    end

    // --------------------------------------------------
    // Slot fill and operand wake-up
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (issue.valid && free_idx == ooo_pkg::slot_idx_t'(i)) begin
                is_br[i]   <= issue.is_br;
                op[i]      <= issue.op;
                vj[i]      <= issue.vj;
                vk[i]      <= issue.vk;
                qj[i]      <= issue.qj;
                qk[i]      <= issue.qk;
                dest[i]    <= issue.dest;
                br_pred[i] <= issue.br_pred;
                pc[i]      <= issue.pc;
                b_imm[i]   <= issue.b_imm;
            end else begin
                if (qj[i] != ooo_pkg::TAG_NONE && rob_ready[qj[i]]) begin
                    vj[i] <= rob_vals[qj[i]];
                    qj[i] <= ooo_pkg::TAG_NONE;
                end
                if (qk[i] != ooo_pkg::TAG_NONE && rob_ready[qk[i]]) begin
                    vk[i] <= rob_vals[qk[i]];
                    qk[i] <= ooo_pkg::TAG_NONE;
                end
            end
        end
    end

    // Dispatch counts its own pending issue against the free slots.
    assert property (@(posedge clk) disable iff (rst || flush)
        issue.valid |-> issue.free_slots != 2'd0)
        else $error("cmp_rs: push with no free slot");

endmodule

`default_nettype wire

//--- design/cmp_writeback.sv
// Write-back stage that registers the result lanes and reports the oldest mispredict.
`timescale 1ns/1ps
`default_nettype none

module cmp_writeback (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    cmp_result_if.wb          res,
    input  ooo_pkg::tag_t     rob_head,
    output logic              res_valid      [ooo_pkg::NUM_CMP_RS],
    output logic              res_mispredict [ooo_pkg::NUM_CMP_RS],
    output rv32i_pkg::word_t  res_val        [ooo_pkg::NUM_CMP_RS],
    output ooo_pkg::tag_t     res_tag        [ooo_pkg::NUM_CMP_RS],
    output logic              redirect_valid,
    output rv32i_pkg::word_t  redirect_pc
);

    localparam int N = ooo_pkg::NUM_CMP_RS;

    ooo_pkg::tag_t      age [N];
    ooo_pkg::tag_t      best_age;
    ooo_pkg::slot_idx_t best_slot;
    logic               found;

    // Distance from the ROB head, wrapping at the tag width.
    for (genvar g = 0; g < N; g++) begin : g_age
        assign age[g] = res.tag[g] - rob_head;
    end

    // --------------------------------------------------
    // Oldest mispredict among this cycle's lanes
    // --------------------------------------------------

    always_comb begin
        found     = 1'b0;
        best_age  = '0;
        best_slot = '0;
        for (int i = 0; i < N; i++) begin
            if (res.valid[i] && res.mispredict[i] && (!found || age[i] < best_age)) begin
                found     = 1'b1;
                best_age  = age[i];
                best_slot = ooo_pkg::slot_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            redirect_valid <= 1'b0;
            for (int i = 0; i < N; i++) begin
                res_valid[i] <= 1'b0;
            end
        end else begin
            redirect_valid <= found;
            for (int i = 0; i < N; i++) begin
                res_valid[i] <= res.valid[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            redirect_pc <= res.val[best_slot];
        end
        for (int i = 0; i < N; i++) begin
            res_val[i]        <= res.val[i];
            res_tag[i]        <= res.tag[i];
            res_mispredict[i] <= res.mispredict[i] && res.valid[i];
        end
    end

endmodule

`default_nettype wire

//--- design/cmp_cluster_top.sv
// Comparator cluster top that joins dispatch, reservation station and write-back.
`timescale 1ns/1ps
`default_nettype none

module cmp_cluster_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                disp_valid,
    input  logic                disp_is_br,
    input  logic                disp_br_pred,
    input  logic                disp_use_imm,
    input  rv32i_pkg::cmp_op_u  disp_op,
    input  ooo_pkg::tag_t       disp_rs1_tag,
    input  ooo_pkg::tag_t       disp_rs2_tag,
    input  ooo_pkg::tag_t       disp_dest,
    input  rv32i_pkg::word_t    disp_rs1_val,
    input  rv32i_pkg::word_t    disp_rs2_val,
    input  rv32i_pkg::word_t    disp_imm,
    input  rv32i_pkg::word_t    disp_pc,
    output logic                disp_ready,
    input  logic                rob_ready [ooo_pkg::ROB_DEPTH],
    input  rv32i_pkg::word_t    rob_vals  [ooo_pkg::ROB_DEPTH],
    input  ooo_pkg::tag_t       rob_head,
    output logic                res_valid      [ooo_pkg::NUM_CMP_RS],
    output logic                res_mispredict [ooo_pkg::NUM_CMP_RS],
    output rv32i_pkg::word_t    res_val        [ooo_pkg::NUM_CMP_RS],
    output ooo_pkg::tag_t       res_tag        [ooo_pkg::NUM_CMP_RS],
    output logic                redirect_valid,
    output rv32i_pkg::word_t    redirect_pc
);

    cmp_issue_if  issue ();
    cmp_result_if result ();

    cmp_dispatch u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .disp_valid   (disp_valid),
        .disp_is_br   (disp_is_br),
        .disp_br_pred (disp_br_pred),
        .disp_use_imm (disp_use_imm),
        .disp_op      (disp_op),
        .disp_rs1_tag (disp_rs1_tag),
        .disp_rs2_tag (disp_rs2_tag),
        .disp_dest    (disp_dest),
        .disp_rs1_val (disp_rs1_val),
        .disp_rs2_val (disp_rs2_val),
        .disp_imm     (disp_imm),
        .disp_pc      (disp_pc),
        .rob_ready    (rob_ready),
        .rob_vals     (rob_vals),
        .disp_ready   (disp_ready),
        .issue        (issue.dispatch)
    );

    cmp_rs u_rs (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .issue     (issue.station),
        .rob_ready (rob_ready),
        .rob_vals  (rob_vals),
        .res       (result.station)
    );

    cmp_writeback u_wb (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .res            (result.wb),
        .rob_head       (rob_head),
        .res_valid      (res_valid),
        .res_mispredict (res_mispredict),
        .res_val        (res_val),
        .res_tag        (res_tag),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- verification/cmp_model_check.svh
// Reference model, scoreboard and checks for the comparator cluster testbench.
`ifndef CMP_MODEL_CHECK_SVH
`define CMP_MODEL_CHECK_SVH

// --------------------------------------------------
// Reference model
// --------------------------------------------------

// Outcome of a compare from the RV32I funct3 rules.
function automatic logic model_taken(logic is_br, logic [2:0] op,
                                     rv32i_pkg::word_t a, rv32i_pkg::word_t b);
    logic lt_s;
    logic lt_u;
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    if (!is_br) begin
        return (op == 3'b010) ? lt_s : lt_u;
    end
    case (op)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return lt_s;
        3'b101:  return !lt_s;
        3'b110:  return lt_u;
        default: return !lt_u;
    endcase
endfunction

// A tagged source takes the final ROB value of its producer.
function automatic rv32i_pkg::word_t operand(ooo_pkg::tag_t t, rv32i_pkg::word_t v);
    return (t != 3'd0) ? rob_vals[t] : v;
endfunction

function automatic int outstanding();
    int n;
    n = 0;
    for (int t = 1; t < 8; t++) begin
        n += int'(inf[t]);
    end
    return n;
endfunction

// A tag still read by an in-flight instruction cannot be reused as a dest.
function automatic logic referenced(ooo_pkg::tag_t t);
    for (int i = 1; i < 8; i++) begin
        if (inf[i] && (m_t1[i] == t || m_t2[i] == t)) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

// Small values now and then, so that equal operands show up.
function automatic rv32i_pkg::word_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    if (r[3:0] == 4'd0) begin
        return {30'd0, r[5:4]};
    end
    return $random(seed);
endfunction

function automatic ooo_pkg::tag_t pick_src(ooo_pkg::tag_t d);
    ooo_pkg::tag_t t;
    if ($unsigned($random(seed)) % 2 == 0) begin
        return 3'd0;
    end
    t = ooo_pkg::tag_t'(1 + $unsigned($random(seed)) % 7);
    return (t == d) ? 3'd0 : t;
endfunction

// --------------------------------------------------
// Stimulus
// --------------------------------------------------

task automatic idle_inputs();
    disp_valid   = 1'b0;
    disp_is_br   = 1'b0;
    disp_br_pred = 1'b0;
    disp_use_imm = 1'b0;
    disp_op      = 3'b010;
    disp_rs1_tag = '0;
    disp_rs2_tag = '0;
    disp_dest    = 3'd1;
    disp_rs1_val = '0;
    disp_rs2_val = '0;
    disp_imm     = '0;
    disp_pc      = '0;
endtask

task automatic new_dispatch();
    ooo_pkg::tag_t cand[$];
    ooo_pkg::tag_t d;
    logic [31:0]   r;
    logic [2:0]    code;
    for (int t = 1; t < 8; t++) begin
        if (!inf[t] && !referenced(ooo_pkg::tag_t'(t))) begin
            cand.push_back(ooo_pkg::tag_t'(t));
        end
    end
    if (cand.size() == 0) begin
        disp_valid = 1'b0;
        return;
    end
    d = cand[$unsigned($random(seed)) % cand.size()];
    r = $random(seed);
    code = r[5:3];
    if (code == 3'd2 || code == 3'd3) begin
        code = {1'b1, r[7:6]};
    end
    disp_valid   = 1'b1;
    disp_dest    = d;
    disp_is_br   = r[0];
    disp_use_imm = !r[0] && r[1];
    disp_br_pred = r[2];
    disp_op      = r[0] ? code : {2'b01, r[8]};
    disp_rs1_tag = pick_src(d);
    disp_rs2_tag = disp_use_imm ? 3'd0 : pick_src(d);
    disp_rs1_val = rand_word();
    disp_rs2_val = rand_word();
    disp_imm     = rand_word();
    disp_pc      = {$random(seed)} & 32'hffff_fffc;
    // The new producer owns its ROB entry until it writes back.
    rob_ready[d] = 1'b0;
endtask

task automatic record_accept();
    ooo_pkg::tag_t t;
    t = disp_dest;
    inf[t]       = 1'b1;
    m_is_br[t]   = disp_is_br;
    m_use_imm[t] = disp_use_imm;
    m_pred[t]    = disp_br_pred;
    m_op[t]      = disp_op;
    m_t1[t]      = disp_rs1_tag;
    m_t2[t]      = disp_rs2_tag;
    m_v1[t]      = disp_rs1_val;
    m_v2[t]      = disp_rs2_val;
    m_imm[t]     = disp_imm;
    m_pc[t]      = disp_pc;
    m_acc[t]     = cyc + 1;
endtask

// Producers outside the cluster finish at random times.
task automatic wake_producers();
    for (int t = 1; t < 8; t++) begin
        if (!rob_ready[t] && !inf[t] && !(hold && disp_dest == t)
            && $unsigned($random(seed)) % 8 == 0) begin
            rob_vals[t]  = $random(seed);
            rob_ready[t] = 1'b1;
        end
    end
endtask

task automatic clear_model();
    for (int t = 0; t < 8; t++) begin
        inf[t] = 1'b0;
    end
endtask

// --------------------------------------------------
// Checks
// --------------------------------------------------

task automatic check_results();
    ooo_pkg::tag_t    t;
    rv32i_pkg::word_t a;
    rv32i_pkg::word_t b;
    rv32i_pkg::word_t exp;
    rv32i_pkg::word_t best_val;
    logic             tk;
    logic             mis;
    logic             found;
    int               age;
    int               best_age;
    int               n;
    found    = 1'b0;
    best_val = '0;
    best_age = 8;
    n        = 0;
    for (int i = 0; i < ooo_pkg::NUM_CMP_RS; i++) begin
        if (res_valid[i]) begin
            t = res_tag[i];
            n++;
            assert (inf[t]) else begin
                $display("Result for tag %0d that is not in flight at %0t", t, $time);
                err_other++;
            end
            if (inf[t]) begin
                // A source tag stays ready until its consumers are done.
                assert ((m_t1[t] == 3'd0 || rob_ready[m_t1[t]])
                        && (m_t2[t] == 3'd0 || rob_ready[m_t2[t]])) else begin
                    $display("Tag %0d completed before its source tags were ready at %0t",
                             t, $time);
                    err_other++;
                end
                a   = operand(m_t1[t], m_v1[t]);
                b   = m_use_imm[t] ? m_imm[t] : operand(m_t2[t], m_v2[t]);
                tk  = model_taken(m_is_br[t], m_op[t], a, b);
                mis = m_is_br[t] && (m_pred[t] != tk);
                if (!m_is_br[t]) begin
                    exp = {31'd0, tk};
                end else begin
                    exp = tk ? m_pc[t] + m_imm[t] : m_pc[t] + 32'd4;
                end
                assert (res_val[i] === exp) else begin
                    $display("Fail %0t res_val[%0d] got %h expected %h",
                             $time, i, res_val[i], exp);
                    err_val++;
                end
                assert (res_mispredict[i] === mis) else begin
                    $display("Fail %0t res_mispredict[%0d] got %b expected %b",
                             $time, i, res_mispredict[i], mis);
                    err_val++;
                end
                assert (cyc - m_acc[t] >= 3) else begin
                    $display("Tag %0d completed only %0d cycles after accept",
                             t, cyc - m_acc[t]);
                    err_other++;
                end
                age = int'(ooo_pkg::tag_t'(t - rob_head));
                if (mis && age < best_age) begin
                    found    = 1'b1;
                    best_age = age;
                    best_val = exp;
                end
                inf[t]       = 1'b0;
                rob_vals[t]  = exp;
                rob_ready[t] = 1'b1;
            end
        end
    end
    assert (redirect_valid === found) else begin
        $display("Fail %0t redirect_valid got %b expected %b", $time, redirect_valid, found);
        err_val++;
    end
    if (found) begin
        assert (redirect_pc === best_val) else begin
            $display("Fail %0t redirect_pc got %h expected %h", $time, redirect_pc, best_val);
            err_val++;
        end
    end
    rob_head = rob_head + ooo_pkg::tag_t'(n);
endtask

task automatic check_idle();
    for (int i = 0; i < ooo_pkg::NUM_CMP_RS; i++) begin
        assert (res_valid[i] === 1'b0) else begin
            $display("Fail %0t res_valid[%0d] got %b expected 0", $time, i, res_valid[i]);
            err_val++;
        end
    end
    assert (redirect_valid === 1'b0) else begin
        $display("Fail %0t redirect_valid got %b expected 0", $time, redirect_valid);
        err_val++;
    end
    assert (disp_ready === 1'b1) else begin
        $display("Fail %0t disp_ready got %b expected 1", $time, disp_ready);
        err_val++;
    end
endtask

// Back-pressure needs at least three accepted instructions without a result.
task automatic check_ready_level();
    if (!disp_ready) begin
        seen_full = 1'b1;
    end
    assert (disp_ready || outstanding() >= 3) else begin
        $display("Fail %0t disp_ready got %b expected 1 with %0d outstanding",
                 $time, disp_ready, outstanding());
        err_val++;
    end
endtask

task automatic check_timeouts();
    for (int t = 1; t < 8; t++) begin
        if (inf[t] && cyc - m_acc[t] > WAIT_LIMIT) begin
            $display("Tag %0d timed out waiting for its result at %0t", t, $time);
            err_other++;
            inf[t] = 1'b0;
        end
    end
endtask

`endif

//--- verification/cmp_tb.sv
// Testbench for the comparator cluster with a random dispatch driver and a ROB model.
`timescale 1ns/1ps
`default_nettype none

module cmp_tb;

    localparam int NUM_CYCLES  = 2000;
    localparam int DRAIN_LIMIT = 300;
    localparam int WAIT_LIMIT  = 100;

    logic               clk;
    logic               rst;
    logic               flush;
    logic               disp_valid;
    logic               disp_is_br;
    logic               disp_br_pred;
    logic               disp_use_imm;
    rv32i_pkg::cmp_op_u disp_op;
    ooo_pkg::tag_t      disp_rs1_tag;
    ooo_pkg::tag_t      disp_rs2_tag;
    ooo_pkg::tag_t      disp_dest;
    rv32i_pkg::word_t   disp_rs1_val;
    rv32i_pkg::word_t   disp_rs2_val;
    rv32i_pkg::word_t   disp_imm;
    rv32i_pkg::word_t   disp_pc;
    logic               disp_ready;
    logic               rob_ready [ooo_pkg::ROB_DEPTH];
    rv32i_pkg::word_t   rob_vals  [ooo_pkg::ROB_DEPTH];
    ooo_pkg::tag_t      rob_head;
    logic               res_valid      [ooo_pkg::NUM_CMP_RS];
    logic               res_mispredict [ooo_pkg::NUM_CMP_RS];
    rv32i_pkg::word_t   res_val        [ooo_pkg::NUM_CMP_RS];
    ooo_pkg::tag_t      res_tag        [ooo_pkg::NUM_CMP_RS];
    logic               redirect_valid;
    rv32i_pkg::word_t   redirect_pc;

    integer seed;
    int     cyc;
    int     drain;
    int     err_val;
    int     err_other;
    logic   hold;
    logic   seen_full;

    // Model of every in-flight instruction, indexed by its dest tag.
    logic             inf       [8];
    logic             m_is_br   [8];
    logic             m_use_imm [8];
    logic             m_pred    [8];
    logic [2:0]       m_op      [8];
    ooo_pkg::tag_t    m_t1      [8];
    ooo_pkg::tag_t    m_t2      [8];
    rv32i_pkg::word_t m_v1      [8];
    rv32i_pkg::word_t m_v2      [8];
    rv32i_pkg::word_t m_imm     [8];
    rv32i_pkg::word_t m_pc      [8];
    int               m_acc     [8];

    `include "cmp_model_check.svh"

    cmp_cluster_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        seed      = 32'h8c1c;
        cyc       = 0;
        drain     = 0;
        err_val   = 0;
        err_other = 0;
        hold      = 1'b0;
        seen_full = 1'b0;
        rst       = 1'b1;
        flush     = 1'b0;
        rob_head  = '0;
        idle_inputs();
        for (int t = 0; t < 8; t++) begin
            rob_ready[t] = 1'b0;
            rob_vals[t]  = '0;
            inf[t]       = 1'b0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // One pass per clock, 2 ns after the rising edge.
        while (cyc < NUM_CYCLES || (outstanding() > 0 && drain < DRAIN_LIMIT)) begin
            @(posedge clk);
            #2;
            cyc++;
            if (cyc >= NUM_CYCLES) begin
                drain++;
            end
            if (flush) begin
                check_idle();
                clear_model();
                flush = 1'b0;
            end else begin
                check_results();
            end
            check_ready_level();
            check_timeouts();
            wake_producers();
            if (!hold) begin
                if (cyc < NUM_CYCLES && $unsigned($random(seed)) % 64 == 0) begin
                    flush      = 1'b1;
                    disp_valid = 1'b0;
                end else if (cyc < NUM_CYCLES && $unsigned($random(seed)) % 4 != 0) begin
                    new_dispatch();
                end else begin
                    disp_valid = 1'b0;
                end
            end
            if (disp_valid && disp_ready) begin
                record_accept();
                hold = 1'b0;
            end else begin
                hold = disp_valid;
            end
        end

        assert (outstanding() == 0) else begin
            $display("Instructions still in flight after the drain window");
            err_other++;
        end
        assert (seen_full) else begin
            $display("disp_ready never fell during the run");
            err_other++;
        end
        $display("errors: value %0d, other %0d", err_val, err_other);
        if (err_val + err_other == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+verification
design/rv32i_pkg.sv
design/ooo_pkg.sv
design/cmp_ifs.sv
design/cmp_unit.sv
design/cmp_dispatch.sv
design/cmp_rs.sv
design/cmp_writeback.sv
design/cmp_cluster_top.sv
verification/cmp_tb.sv

//--- run.sh
#!/bin/sh
# Builds the comparator cluster testbench with Verilator, runs it and checks the log.

rm -f build.log sim.log

verilator --binary --assert --timing -f all.f --top-module cmp_tb -o cmp_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/cmp_sim > sim.log 2>&1

grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
